/* verilog/cbc_pkg.sv */
package cbc_pkg;

  // --------------------------------------------------
  // stream and block geometry
  // --------------------------------------------------
  localparam int WORD_W      = 32;
  localparam int BLOCK_WORDS = 4;
  localparam int BLOCK_W     = WORD_W * BLOCK_WORDS;

  // --------------------------------------------------
  // cipher core
  // --------------------------------------------------
  localparam int ROUND_COUNT = 16;
  localparam int ROUND_W     = 4;
  // left rotate in the round function
  localparam int ROUND_ROT   = 7;

  // controller FSM
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LOAD_KEY,
    ST_WAIT_PAYLOAD,
    ST_READ_IV,
    ST_READ_CT,
    ST_START_CORE,
    ST_WAIT_CORE,
    ST_EMIT
  } ctrl_state_t;

endpackage

/* verilog/feistel_block_core.sv */
module feistel_block_core import cbc_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic [WORD_W-1:0]  key_tdata,
  input  logic               key_load,
  input  logic               core_start,
  input  logic [BLOCK_W-1:0] cipher_in,
  output logic               core_done,
  output logic [BLOCK_W-1:0] plain_raw
);

  logic [BLOCK_W-1:0] key_reg;
  logic [BLOCK_W-1:0] state_reg;
  logic [ROUND_W-1:0] round;
  logic               running;

  logic [1:0]        key_idx;
  logic [WORD_W-1:0] round_key;
  logic [WORD_W-1:0] f_val;
  logic [WORD_W-1:0] w0;
  logic [WORD_W-1:0] w1;
  logic [WORD_W-1:0] w2;
  logic [WORD_W-1:0] w3;

  // --------------------------------------------------
  // round function
  // --------------------------------------------------
  always_comb begin
    w0 = state_reg[BLOCK_W-1          -: WORD_W];
    w1 = state_reg[BLOCK_W-1-WORD_W   -: WORD_W];
    w2 = state_reg[BLOCK_W-1-2*WORD_W -: WORD_W];
    w3 = state_reg[WORD_W-1:0];

    key_idx   = 2'(round % BLOCK_WORDS);
    round_key = key_reg[BLOCK_W-1-WORD_W*key_idx -: WORD_W] + WORD_W'(round);
    f_val     = ((w3 << ROUND_ROT) | (w3 >> (WORD_W - ROUND_ROT))) ^ round_key;
  end

  // round counter, done lands ROUND_COUNT+1 cycles after start
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running   <= 1'b0;
      round     <= '0;
      core_done <= 1'b0;
    end else begin
      core_done <= 1'b0;
      if (core_start) begin
        running <= 1'b1;
        round   <= '0;
      end else if (running) begin
        round <= round + 1'b1;
        if (round == ROUND_W'(ROUND_COUNT - 1)) begin
          running   <= 1'b0;
          core_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    // first key word ends up as k0 in the top bits
    if (key_load) begin
      key_reg <= {key_reg[BLOCK_W-WORD_W-1:0], key_tdata};
    end

    if (core_start) begin
      state_reg <= cipher_in;
    end else if (running) begin
      state_reg <= {w1, w2, w3, w0 ^ f_val};
    end
  end

  // holds the last round result until the next start
  assign plain_raw = state_reg;

  a_key_quiet: assert property (@(posedge clk) disable iff (!reset_n)
    running |-> !key_load);

endmodule

/* verilog/axis_skid_buffer.sv */
module axis_skid_buffer import cbc_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,

  input  logic [WORD_W-1:0] emit_data,
  input  logic              emit_valid,
  input  logic              emit_last,
  output logic              emit_ready,

  output logic [WORD_W-1:0] pt_tdata,
  output logic              pt_tvalid,
  input  logic              pt_tready,
  output logic              pt_tlast
);

  logic [WORD_W-1:0] temp_data;
  logic              temp_last;
  logic              temp_valid;
  logic              out_free;

  // output register can take a word this cycle
  assign out_free   = pt_tready || !pt_tvalid;
  assign emit_ready = !temp_valid;

  // --------------------------------------------------
  // valid flags
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pt_tvalid  <= 1'b0;
      temp_valid <= 1'b0;
    end else if (out_free) begin
      if (temp_valid) begin
        pt_tvalid  <= 1'b1;
        temp_valid <= 1'b0;
      end else begin
        pt_tvalid <= emit_valid;
      end
    end else if (emit_valid) begin
      temp_valid <= 1'b1;
    end
  end

  // --------------------------------------------------
  // payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (out_free) begin
      if (temp_valid) begin
        pt_tdata <= temp_data;
        pt_tlast <= temp_last;
      end else if (emit_valid) begin
        pt_tdata <= emit_data;
        pt_tlast <= emit_last;
      end
    end else if (emit_valid) begin
      // stalled output, park the word
      temp_data <= emit_data;
      temp_last <= emit_last;
    end
  end

  a_hold_stalled: assert property (@(posedge clk) disable iff (!reset_n)
    pt_tvalid && !pt_tready |=> pt_tvalid && $stable(pt_tdata) && $stable(pt_tlast));

endmodule

/* verilog/cbc_chain_datapath.sv */
module cbc_chain_datapath import cbc_pkg::*; (
  input  logic               clk,
  input  logic [WORD_W-1:0]  ct_tdata,
  input  logic               iv_store,
  input  logic               ct_store,
  input  logic [1:0]         word_sel,
  input  logic               chain_update,
  input  logic [1:0]         emit_sel,
  input  logic [BLOCK_W-1:0] plain_raw,
  output logic [BLOCK_W-1:0] cipher_in,
  output logic [WORD_W-1:0]  emit_data
);

  // ciphertext being captured, fed to the core
  logic [BLOCK_W-1:0] ct_reg;
  // IV or ciphertext of the block now in the core
  logic [BLOCK_W-1:0] chain_next;
  // chaining value applied to the current plaintext
  logic [BLOCK_W-1:0] chain_reg;

  logic [WORD_W-1:0] raw_word;
  logic [WORD_W-1:0] chain_word;

  // word 0 sits in the top bits
  function automatic logic [WORD_W-1:0] block_word(input logic [BLOCK_W-1:0] blk,
                                                    input logic [1:0] idx);
    return blk[BLOCK_W-1-WORD_W*idx -: WORD_W];
  endfunction

  // --------------------------------------------------
  // capture and chaining
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (iv_store) begin
      chain_next[BLOCK_W-1-WORD_W*word_sel -: WORD_W] <= ct_tdata;
    end else if (chain_update) begin
      chain_next <= ct_reg;
    end

    if (ct_store) begin
      ct_reg[BLOCK_W-1-WORD_W*word_sel -: WORD_W] <= ct_tdata;
    end

    // old chain_next is the IV or the previous ciphertext block
    if (chain_update) begin
      chain_reg <= chain_next;
    end
  end

  assign cipher_in = ct_reg;

  always_comb begin
    raw_word   = block_word(plain_raw, emit_sel);
    chain_word = block_word(chain_reg, emit_sel);
    emit_data  = raw_word ^ chain_word;
  end

endmodule

/* verilog/cbc_stream_ctrl.sv */
module cbc_stream_ctrl import cbc_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,

  input  logic       key_tvalid,
  output logic       key_tready,
  output logic       key_load,

  input  logic       ct_tvalid,
  output logic       ct_tready,
  input  logic       ct_tlast,

  // datapath capture and chaining
  output logic       iv_store,
  output logic       ct_store,
  output logic [1:0] word_sel,
  output logic       chain_update,

  output logic       core_start,
  input  logic       core_done,

  // towards the skid buffer
  output logic [1:0] emit_sel,
  output logic       emit_valid,
  output logic       emit_last,
  input  logic       emit_ready
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // word position inside key, IV and ciphertext blocks
  logic [1:0] word_cnt;
  logic [1:0] emit_cnt;

  logic core_busy;
  logic blk_ready;
  logic out_pending;
  logic last_seen;
  logic core_last;
  logic ct_fire;

  assign word_sel = word_cnt;
  assign emit_sel = emit_cnt;
  assign key_load = key_tvalid && key_tready;
  assign ct_fire  = ct_tvalid && ct_tready;

  // --------------------------------------------------
  // next state and strobes
  // --------------------------------------------------
  always_comb begin
    state_nxt    = state;
    key_tready   = 1'b0;
    ct_tready    = 1'b0;
    iv_store     = 1'b0;
    ct_store     = 1'b0;
    chain_update = 1'b0;
    core_start   = 1'b0;
    emit_valid   = 1'b0;
    emit_last    = 1'b0;

    case (state)
      ST_IDLE: begin
        if (key_tvalid) begin
          state_nxt = ST_LOAD_KEY;
        end
      end
      ST_LOAD_KEY: begin
        key_tready = 1'b1;
        if (key_tvalid && word_cnt == 2'd3) begin
          state_nxt = ST_WAIT_PAYLOAD;
        end
      end
      ST_WAIT_PAYLOAD: begin
        if (ct_tvalid) begin
          state_nxt = ST_READ_IV;
        end
      end
      ST_READ_IV: begin
        ct_tready = 1'b1;
        iv_store  = ct_tvalid;
        if (ct_tvalid && word_cnt == 2'd3) begin
          state_nxt = ST_READ_CT;
        end
      end
      ST_READ_CT: begin
        // finished plaintext takes priority, capture resumes afterwards
        if (out_pending) begin
          state_nxt = ST_EMIT;
        end else begin
          ct_tready = 1'b1;
          ct_store  = ct_tvalid;
          if (ct_tvalid && word_cnt == 2'd3) begin
            state_nxt = ST_START_CORE;
          end
        end
      end
      ST_START_CORE: begin
        if (out_pending) begin
          state_nxt = ST_EMIT;
        end else if (!core_busy) begin
          // previous block is out, so chaining may advance now
          core_start   = 1'b1;
          chain_update = 1'b1;
          state_nxt    = last_seen ? ST_WAIT_CORE : ST_READ_CT;
        end
      end
      ST_WAIT_CORE: begin
        if (out_pending) begin
          state_nxt = ST_EMIT;
        end
      end
      ST_EMIT: begin
        emit_valid = emit_ready;
        emit_last  = core_last && emit_cnt == 2'd3;
        if (emit_ready && emit_cnt == 2'd3) begin
          if (blk_ready) begin
            state_nxt = ST_START_CORE;
          end else if (core_last) begin
            state_nxt = ST_WAIT_PAYLOAD;
          end else begin
            state_nxt = ST_READ_CT;
          end
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // state, counters and block flags
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state       <= ST_IDLE;
      word_cnt    <= 2'd0;
      emit_cnt    <= 2'd0;
      core_busy   <= 1'b0;
      blk_ready   <= 1'b0;
      out_pending <= 1'b0;
      last_seen   <= 1'b0;
      core_last   <= 1'b0;
    end else begin
      state <= state_nxt;

      // counters wrap at four, so every block starts at word 0
      if (key_load || ct_fire) begin
        word_cnt <= word_cnt + 2'd1;
      end
      if (emit_valid) begin
        emit_cnt <= emit_cnt + 2'd1;
      end

      if (ct_store && word_cnt == 2'd3) begin
        blk_ready <= 1'b1;
        last_seen <= ct_tlast;
      end
      if (state == ST_WAIT_PAYLOAD) begin
        last_seen <= 1'b0;
      end

      if (core_start) begin
        blk_ready <= 1'b0;
        core_busy <= 1'b1;
        core_last <= last_seen;
      end
      if (core_done) begin
        core_busy   <= 1'b0;
        out_pending <= 1'b1;
      end
      if (emit_valid && emit_cnt == 2'd3) begin
        out_pending <= 1'b0;
      end
    end
  end

  // a start needs a fully captured block
  a_start_blk: assert property (@(posedge clk) disable iff (!reset_n)
    core_start |-> blk_ready);

endmodule

/* verilog/cbc_decrypt_top.sv */
module cbc_decrypt_top import cbc_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,

  // key stream
  input  logic [WORD_W-1:0] key_tdata,
  input  logic              key_tvalid,
  output logic              key_tready,

  // IV then ciphertext blocks
  input  logic [WORD_W-1:0] ct_tdata,
  input  logic              ct_tvalid,
  output logic              ct_tready,
  input  logic              ct_tlast,

  // plaintext stream
  output logic [WORD_W-1:0] pt_tdata,
  output logic              pt_tvalid,
  input  logic              pt_tready,
  output logic              pt_tlast
);

  logic               key_load;
  logic               iv_store;
  logic               ct_store;
  logic [1:0]         word_sel;
  logic               chain_update;
  logic               core_start;
  logic               core_done;
  logic [1:0]         emit_sel;
  logic               emit_valid;
  logic               emit_last;
  logic               emit_ready;
  logic [BLOCK_W-1:0] cipher_in;
  logic [BLOCK_W-1:0] plain_raw;
  logic [WORD_W-1:0]  emit_data;

  cbc_stream_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .key_tvalid   (key_tvalid),
    .key_tready   (key_tready),
    .key_load     (key_load),
    .ct_tvalid    (ct_tvalid),
    .ct_tready    (ct_tready),
    .ct_tlast     (ct_tlast),
    .iv_store     (iv_store),
    .ct_store     (ct_store),
    .word_sel     (word_sel),
    .chain_update (chain_update),
    .core_start   (core_start),
    .core_done    (core_done),
    .emit_sel     (emit_sel),
    .emit_valid   (emit_valid),
    .emit_last    (emit_last),
    .emit_ready   (emit_ready)
  );

  cbc_chain_datapath u_datapath (
    .clk          (clk),
    .ct_tdata     (ct_tdata),
    .iv_store     (iv_store),
    .ct_store     (ct_store),
    .word_sel     (word_sel),
    .chain_update (chain_update),
    .emit_sel     (emit_sel),
    .plain_raw    (plain_raw),
    .cipher_in    (cipher_in),
    .emit_data    (emit_data)
  );

  feistel_block_core u_core (
    .clk        (clk),
    .reset_n    (reset_n),
    .key_tdata  (key_tdata),
    .key_load   (key_load),
    .core_start (core_start),
    .cipher_in  (cipher_in),
    .core_done  (core_done),
    .plain_raw  (plain_raw)
  );

  axis_skid_buffer u_skid (
    .clk        (clk),
    .reset_n    (reset_n),
    .emit_data  (emit_data),
    .emit_valid (emit_valid),
    .emit_last  (emit_last),
    .emit_ready (emit_ready),
    .pt_tdata   (pt_tdata),
    .pt_tvalid  (pt_tvalid),
    .pt_tready  (pt_tready),
    .pt_tlast   (pt_tlast)
  );

endmodule

/* dv/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // low for three rising edges
  initial begin
    reset_n = 1'b0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

/* dv/cbc_ref_model.svh */
`ifndef CBC_REF_MODEL_SVH
`define CBC_REF_MODEL_SVH

function automatic logic [31:0] rotl_word(input logic [31:0] x, input int n);
  return (x << n) | (x >> (32 - n));
endfunction

// key word i mod 4 plus the round number
function automatic logic [31:0] round_key(input logic [127:0] key, input int rnd);
  logic [31:0] k;
  k = key[127 - 32 * (rnd % 4) -: 32];
  return k + 32'(rnd);
endfunction

function automatic logic [127:0] ref_decrypt(input logic [127:0] ct, input logic [127:0] key);
  logic [31:0] w [4];
  logic [31:0] f;
  logic [31:0] t;
  for (int i = 0; i < 4; i++) begin
    w[i] = ct[127 - 32 * i -: 32];
  end
  for (int r = 0; r < 16; r++) begin
    f    = rotl_word(w[3], 7) ^ round_key(key, r);
    t    = w[0] ^ f;
    w[0] = w[1];
    w[1] = w[2];
    w[2] = w[3];
    w[3] = t;
  end
  return {w[0], w[1], w[2], w[3]};
endfunction

`endif

/* dv/tb_cbc_decrypt.sv */
module tb_cbc_decrypt import cbc_pkg::*; ();

  `include "cbc_ref_model.svh"

  localparam int TIMEOUT      = 2000;
  localparam int NUM_TESTS    = 6;
  localparam int READY_ALWAYS = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_STALL  = 2;

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  string test_name   [NUM_TESTS] = '{"single_block", "five_blocks", "random_ready",
                                     "long_stall", "new_iv", "key_change"};
  int    test_blocks [NUM_TESTS] = '{1, 5, 4, 3, 2, 3};
  bit    test_reload [NUM_TESTS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  int    test_ready  [NUM_TESTS] = '{READY_ALWAYS, READY_ALWAYS, READY_RANDOM,
                                     READY_STALL, READY_ALWAYS, READY_RANDOM};

  logic              clk;
  logic              por_n;
  logic              soft_rst_n;
  logic              reset_n;
  logic [WORD_W-1:0] key_tdata;
  logic              key_tvalid;
  logic              key_tready;
  logic [WORD_W-1:0] ct_tdata;
  logic              ct_tvalid;
  logic              ct_tready;
  logic              ct_tlast;
  logic [WORD_W-1:0] pt_tdata;
  logic              pt_tvalid;
  logic              pt_tready;
  logic              pt_tlast;

  logic [BLOCK_W-1:0] ct_blocks [$];
  logic [WORD_W-1:0]  exp_words [$];

  assign reset_n = por_n && soft_rst_n;

  tb_clock_gen u_clk_gen (
    .clk     (clk),
    .reset_n (por_n)
  );

  cbc_decrypt_top UUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .key_tdata  (key_tdata),
    .key_tvalid (key_tvalid),
    .key_tready (key_tready),
    .ct_tdata   (ct_tdata),
    .ct_tvalid  (ct_tvalid),
    .ct_tready  (ct_tready),
    .ct_tlast   (ct_tlast),
    .pt_tdata   (pt_tdata),
    .pt_tvalid  (pt_tvalid),
    .pt_tready  (pt_tready),
    .pt_tlast   (pt_tlast)
  );

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [BLOCK_W-1:0] random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // three cycles of reset, returns on a rising edge
  task automatic apply_reset();
    soft_rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    soft_rst_n <= 1'b1;
  endtask

  // called on a rising edge, returns on the edge of the transfer
  task automatic send_key_word(input logic [WORD_W-1:0] data);
    int waited;
    waited = 0;
    key_tdata  <= data;
    key_tvalid <= 1'b1;
    @(negedge clk);
    while (!key_tready) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_timeout("key_tready");
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic send_ct_word(input logic [WORD_W-1:0] data, input logic last);
    int waited;
    waited = 0;
    ct_tdata  <= data;
    ct_tvalid <= 1'b1;
    ct_tlast  <= last;
    @(negedge clk);
    while (!ct_tready) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_timeout("ct_tready");
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // IV first, then every block, tlast on the final word
  task automatic send_message(input logic [BLOCK_W-1:0] iv);
    int nblk;
    nblk = ct_blocks.size();
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      send_ct_word(iv[BLOCK_W-1-WORD_W*i -: WORD_W], 1'b0);
    end
    for (int b = 0; b < nblk; b++) begin
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        send_ct_word(ct_blocks[b][BLOCK_W-1-WORD_W*i -: WORD_W],
                     (b == nblk - 1) && (i == BLOCK_WORDS - 1));
      end
    end
    ct_tvalid <= 1'b0;
    ct_tlast  <= 1'b0;
  endtask

  // --------------------------------------------------
  // output monitor
  // --------------------------------------------------
  task automatic collect_output(input string name, input int mode);
    int   idle;
    int   got;
    int   stall_left;
    logic exp_last;
    idle       = 0;
    got        = 0;
    stall_left = 0;
    while (got < exp_words.size()) begin
      @(posedge clk);
      case (mode)
        READY_RANDOM: pt_tready <= ($urandom % 2) == 1;
        READY_STALL:  pt_tready <= (stall_left == 0);
        default:      pt_tready <= 1'b1;
      endcase
      if (stall_left > 0) begin
        stall_left--;
      end
      @(negedge clk);
      if (pt_tvalid && pt_tready) begin
        exp_last = (got == exp_words.size() - 1);
        check_value($sformatf("%s word %0d", name, got), exp_words[got], pt_tdata);
        check_value($sformatf("%s tlast %0d", name, got), exp_last, pt_tlast);
        got++;
        idle = 0;
        // hold the output stalled once the first word is out
        if (mode == READY_STALL && got == 1) begin
          stall_left = 60;
        end
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          report_timeout("plaintext output");
        end
      end
    end
  endtask

  initial begin
    logic [BLOCK_W-1:0] key;
    logic [BLOCK_W-1:0] iv;
    logic [BLOCK_W-1:0] prev;
    logic [BLOCK_W-1:0] plain;
    int                 waited;

    void'($urandom(35457));
    key_tdata  = '0;
    key_tvalid = 1'b0;
    ct_tdata   = '0;
    ct_tvalid  = 1'b0;
    ct_tlast   = 1'b0;
    pt_tready  = 1'b0;
    soft_rst_n = 1'b1;
    key        = '0;

    waited = 0;
    while (por_n !== 1'b1) begin
      @(posedge clk);
      waited++;
      if (waited > 20) begin
        report_timeout("reset release");
      end
    end
    @(negedge clk);
    check_value("reset key_tready", 0, key_tready);
    check_value("reset ct_tready", 0, ct_tready);
    check_value("reset pt_tvalid", 0, pt_tvalid);
    @(posedge clk);

    for (int t = 0; t < NUM_TESTS; t++) begin
      if (test_reload[t]) begin
        apply_reset();
        key = random_block();
        for (int i = 0; i < BLOCK_WORDS; i++) begin
          send_key_word(key[BLOCK_W-1-WORD_W*i -: WORD_W]);
        end
        key_tvalid <= 1'b0;
      end

      // expected plaintext, each block chained on the one before
      iv = random_block();
      ct_blocks.delete();
      exp_words.delete();
      prev = iv;
      for (int b = 0; b < test_blocks[t]; b++) begin
        ct_blocks.push_back(random_block());
        plain = ref_decrypt(ct_blocks[b], key) ^ prev;
        prev  = ct_blocks[b];
        for (int i = 0; i < BLOCK_WORDS; i++) begin
          exp_words.push_back(plain[BLOCK_W-1-WORD_W*i -: WORD_W]);
        end
      end

      fork
        send_message(iv);
        collect_output(test_name[t], test_ready[t]);
      join

      // nothing left over after the message
      repeat (4) begin
        @(negedge clk);
        check_value({test_name[t], " extra word"}, 0, pt_tvalid);
      end
      @(posedge clk);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

/* build.f */
+incdir+dv
verilog/cbc_pkg.sv
verilog/feistel_block_core.sv
verilog/axis_skid_buffer.sv
verilog/cbc_chain_datapath.sv
verilog/cbc_stream_ctrl.sv
verilog/cbc_decrypt_top.sv
dv/tb_clock_gen.sv
dv/tb_cbc_decrypt.sv
